//--- common/ctrl_pkg.sv
////////////////////
// Pipeline stage contents and controller output types
// Stage masks use bit 0 for IF up to bit 3 for WB
////////////////////
`default_nettype none

package ctrl_pkg;

  // Exception cause codes
  typedef logic [4:0] exc_code_t;
  localparam exc_code_t EXC_BUS_FAULT  = 5'd1;
  localparam exc_code_t EXC_ILLEGAL    = 5'd2;
  localparam exc_code_t EXC_BREAKPOINT = 5'd3;
  localparam exc_code_t EXC_ECALL_M    = 5'd11;

  // One bit per pipeline stage
  typedef logic [3:0] stage_mask_t;
  localparam stage_mask_t MASK_IF  = 4'b0001;
  localparam stage_mask_t MASK_ID  = 4'b0010;
  localparam stage_mask_t MASK_EX  = 4'b0100;
  localparam stage_mask_t MASK_WB  = 4'b1000;

  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_EXCEPTION,
    PC_DRET
  } pc_mux_e;

  // Handler target when PC_EXCEPTION is selected
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBE
  } exc_pc_e;

  typedef struct packed {
    logic valid;
    logic jump;
    logic jr_stall;
  } id_stage_t;

  typedef struct packed {
    logic valid;
    logic branch;
    logic branch_taken;
    logic data_misaligned;
  } ex_stage_t;

  typedef struct packed {
    logic valid;
    logic bus_err;
    logic illegal;
    logic ecall;
    logic ebreak;
    logic wfi;
    logic dret;
    logic data_req;
  } wb_stage_t;

  // WB flags already qualified with valid
  typedef struct packed {
    logic      exception;
    exc_code_t exc_code;
    logic      wfi;
    logic      dret;
    logic      ebreak;
  } wb_event_t;

  typedef struct packed {
    logic        instr_req;
    logic        busy;
    logic        pc_set;
    pc_mux_e     pc_mux;
    exc_pc_e     exc_pc_mux;
    stage_mask_t kill;
    stage_mask_t halt;
    // One-hot, selects the stage whose PC goes to the CSRs
    stage_mask_t csr_save_stage;
    logic        csr_save_cause;
    logic        debug_csr_save;
  } ctrl_out_t;

endpackage

`default_nettype wire

//--- common/dbg_pkg.sv
////////////////////
// Debug status encoding, one-hot over three states
////////////////////
`default_nettype none

package dbg_pkg;

  // One-hot debug status states
  typedef enum logic [2:0] {
    HAVERESET = 3'b001,
    RUNNING   = 3'b010,
    HALTED    = 3'b100
  } dbg_state_e;

  // Status bits as seen by the debug module
  typedef struct packed {
    logic havereset;
    logic running;
    logic halted;
  } dbg_status_t;

endpackage

`default_nettype wire

//--- rtl/ctrl_event_decode.sv
////////////////////
// Exception priority is bus fault, illegal, ecall, breakpoint
////////////////////
`timescale 1ns/1ns
`default_nettype none

module ctrl_event_decode (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire ctrl_pkg::id_stage_t  id_i,
  input  wire ctrl_pkg::ex_stage_t  ex_i,
  input  wire ctrl_pkg::wb_stage_t  wb_i,
  input  wire logic                 data_req_i,
  input  wire logic                 ex_valid_i,
  input  wire logic                 debug_mode_i,
  output ctrl_pkg::wb_event_t       wb_evt_o,
  output logic                      branch_taken_o,
  output logic                      jump_taken_o,
  output logic                      irq_allowed_o,
  output logic                      debug_allowed_o
);

  import ctrl_pkg::*;

  // Data request issued while its instruction is still in EX
  logic data_req_q;
  logic lsu_in_wb;
  logic misaligned_ex;

  ////////////////////
  // WB events
  ////////////////////
  assign wb_evt_o.exception = wb_i.valid &&
                              (wb_i.bus_err || wb_i.illegal || wb_i.ecall || wb_i.ebreak);
  assign wb_evt_o.exc_code  = wb_i.bus_err ? EXC_BUS_FAULT :
                              wb_i.illegal ? EXC_ILLEGAL   :
                              wb_i.ecall   ? EXC_ECALL_M   :
                                             EXC_BREAKPOINT;
  assign wb_evt_o.wfi       = wb_i.valid && wb_i.wfi;
  assign wb_evt_o.dret      = wb_i.valid && wb_i.dret;
  assign wb_evt_o.ebreak    = wb_i.valid && wb_i.ebreak;

  // Control transfers from EX and ID
  assign branch_taken_o = ex_i.valid && ex_i.branch && ex_i.branch_taken;
  assign jump_taken_o   = id_i.valid && id_i.jump && !id_i.jr_stall;

  ////////////////////
  // Outstanding LSU
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_req_q <= 1'b0;
    end else if (data_req_i && !ex_valid_i) begin
      data_req_q <= 1'b1;
    end else if (ex_valid_i) begin
      data_req_q <= 1'b0;
    end
  end

  assign lsu_in_wb     = wb_i.valid && wb_i.data_req;
  assign misaligned_ex = ex_i.valid && ex_i.data_misaligned;

  // Debug kills WB, so a load or store there must finish first
  assign debug_allowed_o = !lsu_in_wb && !data_req_q;

  // A faulting instruction in WB never reached the bus
  assign irq_allowed_o = ((!lsu_in_wb && !data_req_q && !misaligned_ex) ||
                          wb_evt_o.exception) && !debug_mode_i;

endmodule

`default_nettype wire

//--- rtl/ctrl_main_fsm.sv
////////////////////
// IRQ_ID_W must be 5 or more
// Outputs are combinational from state and inputs
////////////////////
`timescale 1ns/1ns
`default_nettype none

module ctrl_main_fsm #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 fetch_enable_i,
  input  wire ctrl_pkg::wb_event_t  wb_evt_i,
  input  wire logic                 branch_taken_i,
  input  wire logic                 jump_taken_i,
  input  wire logic                 irq_allowed_i,
  input  wire logic                 debug_allowed_i,
  input  wire logic                 irq_req_i,
  input  wire logic                 irq_wakeup_i,
  input  wire logic [IRQ_ID_W-1:0]  irq_id_i,
  input  wire logic                 debug_mode_i,
  input  wire logic                 debug_pending_i,
  input  wire logic                 id_valid_i,
  input  wire logic                 ex_valid_stage_i,
  input  wire logic                 wb_valid_i,
  output ctrl_pkg::ctrl_out_t       ctrl_o,
  output logic                      irq_ack_o,
  output logic [IRQ_ID_W-1:0]       irq_id_o,
  output logic [IRQ_ID_W:0]         csr_cause_o,
  output logic                      enter_debug_o,
  output logic                      exit_debug_o,
  output logic                      booting_o
);

  import ctrl_pkg::*;

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    FUNCTIONAL,
    SLEEP,
    DEBUG_TAKEN
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  stage_mask_t oldest_stage;

  // Oldest valid stage, IF always holds a valid PC
  assign oldest_stage = wb_valid_i       ? MASK_WB :
                        ex_valid_stage_i ? MASK_EX :
                        id_valid_i       ? MASK_ID :
                                           MASK_IF;

  always_comb begin
    state_d                = state_q;
    ctrl_o.instr_req       = 1'b1;
    ctrl_o.busy            = 1'b1;
    ctrl_o.pc_set          = 1'b0;
    ctrl_o.pc_mux          = PC_BOOT;
    ctrl_o.exc_pc_mux      = EXC_PC_IRQ;
    ctrl_o.kill            = '0;
    ctrl_o.halt            = '0;
    ctrl_o.csr_save_stage  = '0;
    ctrl_o.csr_save_cause  = 1'b0;
    ctrl_o.debug_csr_save  = 1'b0;
    irq_ack_o              = 1'b0;
    irq_id_o               = '0;
    csr_cause_o            = '0;
    enter_debug_o          = 1'b0;
    exit_debug_o           = 1'b0;
    booting_o              = 1'b0;

    case (state_q)
      RESET: begin
        ctrl_o.instr_req = 1'b0;
        if (fetch_enable_i) begin
          booting_o = 1'b1;
          state_d   = BOOT_SET;
        end
      end
      // Boot PC set one cycle after enable
      BOOT_SET: begin
        ctrl_o.pc_set = 1'b1;
        ctrl_o.pc_mux = PC_BOOT;
        state_d       = FUNCTIONAL;
      end
      FUNCTIONAL: begin
        if (debug_pending_i) begin
          if (debug_allowed_i) begin
            ctrl_o.halt = '1;
            state_d     = DEBUG_TAKEN;
          end else begin
            // Hold off new issue until the LSU drains
            ctrl_o.halt = MASK_ID;
          end
        end else if (irq_req_i && !debug_mode_i) begin
          if (irq_allowed_i) begin
            ctrl_o.kill           = '1;
            ctrl_o.pc_set         = 1'b1;
            ctrl_o.pc_mux         = PC_EXCEPTION;
            ctrl_o.exc_pc_mux     = EXC_PC_IRQ;
            ctrl_o.csr_save_stage = oldest_stage;
            ctrl_o.csr_save_cause = 1'b1;
            irq_ack_o             = 1'b1;
            irq_id_o              = irq_id_i;
            csr_cause_o           = {1'b1, irq_id_i};
          end else begin
            ctrl_o.halt = MASK_ID;
          end
        end else if (wb_evt_i.exception) begin
          ctrl_o.kill           = '1;
          ctrl_o.pc_set         = 1'b1;
          ctrl_o.pc_mux         = PC_EXCEPTION;
          ctrl_o.exc_pc_mux     = debug_mode_i ? EXC_PC_DBE : EXC_PC_EXCEPTION;
          ctrl_o.csr_save_stage = MASK_WB;
          // mcause untouched in debug mode
          ctrl_o.csr_save_cause = !debug_mode_i;
          csr_cause_o           = {1'b0, IRQ_ID_W'(wb_evt_i.exc_code)};
        end else if (wb_evt_i.wfi) begin
          // EX and WB keep moving so the core sleeps on a bubble
          if (!debug_mode_i) begin
            ctrl_o.instr_req = 1'b0;
            ctrl_o.halt      = MASK_IF | MASK_ID;
            state_d          = SLEEP;
          end
        end else if (wb_evt_i.dret) begin
          ctrl_o.kill   = MASK_IF | MASK_ID | MASK_EX;
          ctrl_o.pc_set = 1'b1;
          ctrl_o.pc_mux = PC_DRET;
          exit_debug_o  = 1'b1;
        end else if (branch_taken_i) begin
          ctrl_o.kill   = MASK_IF | MASK_ID;
          ctrl_o.pc_set = 1'b1;
          ctrl_o.pc_mux = PC_BRANCH;
        end else if (jump_taken_i) begin
          ctrl_o.kill   = MASK_IF;
          ctrl_o.pc_set = 1'b1;
          ctrl_o.pc_mux = PC_JUMP;
        end
      end
      SLEEP: begin
        ctrl_o.instr_req = 1'b0;
        ctrl_o.busy      = 1'b0;
        ctrl_o.halt      = '1;
        if (irq_wakeup_i || debug_pending_i) begin
          ctrl_o.busy = 1'b1;
          state_d     = FUNCTIONAL;
        end
      end
      DEBUG_TAKEN: begin
        ctrl_o.kill           = '1;
        ctrl_o.pc_set         = 1'b1;
        ctrl_o.pc_mux         = PC_EXCEPTION;
        ctrl_o.exc_pc_mux     = EXC_PC_DBD;
        ctrl_o.csr_save_stage = oldest_stage;
        ctrl_o.csr_save_cause = 1'b1;
        ctrl_o.debug_csr_save = 1'b1;
        enter_debug_o         = 1'b1;
        state_d               = FUNCTIONAL;
      end
      default: begin
        ctrl_o.instr_req = 1'b0;
        state_d          = RESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/ctrl_debug_status.sv
////////////////////
// Sticky halt request runs on the core clock
////////////////////
`timescale 1ns/1ns
`default_nettype none

module ctrl_debug_status (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          debug_req_i,
  input  wire logic          enter_debug_i,
  input  wire logic          exit_debug_i,
  input  wire logic          booting_i,
  output logic               debug_mode_o,
  output logic               debug_pending_o,
  output dbg_pkg::dbg_status_t status_o
);

  import dbg_pkg::*;

  logic       debug_req_q;
  logic       debug_mode_d;
  dbg_state_e state_q;
  dbg_state_e state_d;

  // Keep a short request pulse until debug mode is reached
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_req_q <= 1'b0;
    end else if (debug_req_i) begin
      debug_req_q <= 1'b1;
    end else if (debug_mode_o) begin
      debug_req_q <= 1'b0;
    end
  end

  assign debug_pending_o = (debug_req_i || debug_req_q) && !debug_mode_o;

  // Mode flag, entry wins over exit
  assign debug_mode_d = enter_debug_i ? 1'b1 :
                        exit_debug_i  ? 1'b0 :
                                        debug_mode_o;

  ////////////////////
  // Status machine
  ////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      HAVERESET: begin
        if (debug_mode_d) begin
          state_d = HALTED;
        end else if (booting_i) begin
          state_d = RUNNING;
        end
      end
      RUNNING: begin
        if (debug_mode_d) begin
          state_d = HALTED;
        end
      end
      HALTED: begin
        if (!debug_mode_d) begin
          state_d = RUNNING;
        end
      end
      default: begin
        state_d = HAVERESET;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_mode_o <= 1'b0;
      state_q      <= HAVERESET;
    end else begin
      debug_mode_o <= debug_mode_d;
      state_q      <= state_d;
    end
  end

  assign status_o.havereset = (state_q == HAVERESET);
  assign status_o.running   = (state_q == RUNNING);
  assign status_o.halted    = (state_q == HALTED);

endmodule

`default_nettype wire

//--- rtl/ctrl_top.sv
////////////////////
// Pipeline controller top, IRQ_ID_W of 5 or more
////////////////////
`timescale 1ns/1ns
`default_nettype none

module ctrl_top #(
  parameter int unsigned IRQ_ID_W = 5
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 fetch_enable_i,
  input  wire ctrl_pkg::id_stage_t  id_i,
  input  wire ctrl_pkg::ex_stage_t  ex_i,
  input  wire ctrl_pkg::wb_stage_t  wb_i,
  input  wire logic                 irq_req_i,
  input  wire logic [IRQ_ID_W-1:0]  irq_id_i,
  input  wire logic                 irq_wakeup_i,
  input  wire logic                 debug_req_i,
  input  wire logic                 data_req_i,
  input  wire logic                 ex_valid_i,
  output ctrl_pkg::ctrl_out_t       ctrl_o,
  output logic                      irq_ack_o,
  output logic [IRQ_ID_W-1:0]       irq_id_o,
  output logic [IRQ_ID_W:0]         csr_cause_o,
  output logic                      debug_mode_o,
  output dbg_pkg::dbg_status_t      debug_status_o
);

  import ctrl_pkg::*;

  // Decode to FSM
  wb_event_t wb_evt;
  logic      branch_taken_ex;
  logic      jump_taken_id;
  logic      irq_allowed;
  logic      debug_allowed;
  // Debug block and FSM handshake pulses
  logic      debug_pending;
  logic      enter_debug;
  logic      exit_debug;
  logic      booting;

  ctrl_event_decode u_event_decode (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_i            (id_i),
    .ex_i            (ex_i),
    .wb_i            (wb_i),
    .data_req_i      (data_req_i),
    .ex_valid_i      (ex_valid_i),
    .debug_mode_i    (debug_mode_o),
    .wb_evt_o        (wb_evt),
    .branch_taken_o  (branch_taken_ex),
    .jump_taken_o    (jump_taken_id),
    .irq_allowed_o   (irq_allowed),
    .debug_allowed_o (debug_allowed)
  );

  ctrl_main_fsm #(
    .IRQ_ID_W (IRQ_ID_W)
  ) u_main_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_enable_i   (fetch_enable_i),
    .wb_evt_i         (wb_evt),
    .branch_taken_i   (branch_taken_ex),
    .jump_taken_i     (jump_taken_id),
    .irq_allowed_i    (irq_allowed),
    .debug_allowed_i  (debug_allowed),
    .irq_req_i        (irq_req_i),
    .irq_wakeup_i     (irq_wakeup_i),
    .irq_id_i         (irq_id_i),
    .debug_mode_i     (debug_mode_o),
    .debug_pending_i  (debug_pending),
    .id_valid_i       (id_i.valid),
    .ex_valid_stage_i (ex_i.valid),
    .wb_valid_i       (wb_i.valid),
    .ctrl_o           (ctrl_o),
    .irq_ack_o        (irq_ack_o),
    .irq_id_o         (irq_id_o),
    .csr_cause_o      (csr_cause_o),
    .enter_debug_o    (enter_debug),
    .exit_debug_o     (exit_debug),
    .booting_o        (booting)
  );

  ctrl_debug_status u_debug_status (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .enter_debug_i   (enter_debug),
    .exit_debug_i    (exit_debug),
    .booting_i       (booting),
    .debug_mode_o    (debug_mode_o),
    .debug_pending_o (debug_pending),
    .status_o        (debug_status_o)
  );

endmodule

`default_nettype wire

//--- verification/ctrl_tb.sv
////////////////////
// Checks run as concurrent assertions on the rising edge
// Expectations are driven with the stimulus one cycle ahead
////////////////////
`timescale 1ns/1ns
`default_nettype none

module ctrl_tb;

  import ctrl_pkg::*;
  import dbg_pkg::*;

  localparam int unsigned IRQ_ID_W   = 5;
  localparam int unsigned CLK_PERIOD = 40;
  // Tests take about 80 cycles
  localparam int unsigned MAX_CYCLES = 2000;

  logic                clk;
  logic                rst_n;
  logic                fetch_enable_i;
  id_stage_t           id_i;
  ex_stage_t           ex_i;
  wb_stage_t           wb_i;
  logic                irq_req_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic                irq_wakeup_i;
  logic                debug_req_i;
  logic                data_req_i;
  logic                ex_valid_i;
  ctrl_out_t           ctrl_o;
  logic                irq_ack_o;
  logic [IRQ_ID_W-1:0] irq_id_o;
  logic [IRQ_ID_W:0]   csr_cause_o;
  logic                debug_mode_o;
  dbg_status_t         debug_status_o;

  // Check enables and expected values
  logic                booted;
  logic                chk_ctl;
  logic                chk_cause;
  logic                chk_irq;
  logic                chk_mode;
  logic                chk_status;
  ctrl_out_t           exp_ctl;
  logic [IRQ_ID_W:0]   exp_cause;
  logic [IRQ_ID_W:0]   exp_irq;
  logic                exp_mode;
  dbg_status_t         exp_status;
  ctrl_out_t           ctl_seen;
  logic [4:0]          boot_view;
  logic [3:0]          pc_view;
  logic [2:0]          run_view;
  logic [IRQ_ID_W:0]   irq_view;
  int unsigned         errors;
  int unsigned         cycles;
  string               test_name;

  ctrl_top #(
    .IRQ_ID_W (IRQ_ID_W)
  ) dut0 (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .id_i           (id_i),
    .ex_i           (ex_i),
    .wb_i           (wb_i),
    .irq_req_i      (irq_req_i),
    .irq_id_i       (irq_id_i),
    .irq_wakeup_i   (irq_wakeup_i),
    .debug_req_i    (debug_req_i),
    .data_req_i     (data_req_i),
    .ex_valid_i     (ex_valid_i),
    .ctrl_o         (ctrl_o),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .csr_cause_o    (csr_cause_o),
    .debug_mode_o   (debug_mode_o),
    .debug_status_o (debug_status_o)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, tests did not complete", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////
  // Reference helpers
  ////////////////////
  // Mux fields only matter when a PC is set
  function automatic ctrl_out_t visible_ctl(input ctrl_out_t c);
    ctrl_out_t v;
    v = c;
    if (!v.pc_set) begin
      v.pc_mux = PC_BOOT;
    end
    if (v.pc_mux != PC_EXCEPTION) begin
      v.exc_pc_mux = EXC_PC_EXCEPTION;
    end
    return v;
  endfunction

  // Fetching, busy, nothing else
  function automatic ctrl_out_t idle_ctl();
    ctrl_out_t c;
    c            = '0;
    c.instr_req  = 1'b1;
    c.busy       = 1'b1;
    c.pc_mux     = PC_BOOT;
    c.exc_pc_mux = EXC_PC_EXCEPTION;
    return c;
  endfunction

  function automatic ctrl_out_t redirect_ctl(input stage_mask_t kill, input pc_mux_e mux);
    ctrl_out_t c;
    c        = idle_ctl();
    c.kill   = kill;
    c.pc_set = 1'b1;
    c.pc_mux = mux;
    return c;
  endfunction

  // Bus fault first, breakpoint last
  function automatic exc_code_t expected_exc_code(input wb_stage_t w);
    if (w.bus_err) begin
      return EXC_BUS_FAULT;
    end else if (w.illegal) begin
      return EXC_ILLEGAL;
    end else if (w.ecall) begin
      return EXC_ECALL_M;
    end
    return EXC_BREAKPOINT;
  endfunction

  function automatic stage_mask_t oldest_valid_stage(input logic id_v, input logic ex_v,
                                                     input logic wb_v);
    if (wb_v) begin
      return MASK_WB;
    end else if (ex_v) begin
      return MASK_EX;
    end else if (id_v) begin
      return MASK_ID;
    end
    return MASK_IF;
  endfunction

  task automatic report_mismatch(input string check, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    errors++;
    $display("mismatch %s (%s): expected %0h actual %0h", test_name, check, exp_v, act_v);
  endtask

  ////////////////////
  // Assertions
  ////////////////////
  assign ctl_seen  = visible_ctl(ctrl_o);
  assign boot_view = {ctrl_o.instr_req, ctrl_o.pc_set, ctrl_o.busy,
                      debug_status_o.havereset, irq_ack_o};
  assign pc_view   = {ctrl_o.pc_set, ctrl_o.pc_mux};
  assign run_view  = {ctrl_o.pc_set, ctrl_o.instr_req, debug_status_o.running};
  assign irq_view  = {irq_ack_o, irq_id_o};

  reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !booted |-> boot_view == 5'b00110)
    else report_mismatch("reset_idle", 32'(5'b00110), 32'($sampled(boot_view)));

  // Boot PC one cycle after enable
  boot_pc: assert property (@(posedge clk) disable iff (!rst_n)
    $past(fetch_enable_i && debug_status_o.havereset) |-> pc_view == {1'b1, PC_BOOT})
    else report_mismatch("boot_pc", 32'({1'b1, PC_BOOT}), 32'($sampled(pc_view)));

  boot_run: assert property (@(posedge clk) disable iff (!rst_n)
    $past(fetch_enable_i && debug_status_o.havereset, 2) |-> run_view == 3'b011)
    else report_mismatch("boot_run", 32'(3'b011), 32'($sampled(run_view)));

  ctl_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_ctl |-> ctl_seen == exp_ctl)
    else report_mismatch("ctrl", 32'($sampled(exp_ctl)), 32'($sampled(ctl_seen)));

  cause_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_cause |-> csr_cause_o == exp_cause)
    else report_mismatch("cause", 32'($sampled(exp_cause)), 32'($sampled(csr_cause_o)));

  irq_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_irq |-> irq_view == exp_irq)
    else report_mismatch("irq_ack", 32'($sampled(exp_irq)), 32'($sampled(irq_view)));

  mode_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_mode |-> debug_mode_o == exp_mode)
    else report_mismatch("debug_mode", 32'($sampled(exp_mode)), 32'($sampled(debug_mode_o)));

  status_check: assert property (@(posedge clk) disable iff (!rst_n)
    chk_status |-> debug_status_o == exp_status)
    else report_mismatch("status", 32'($sampled(exp_status)),
                         32'($sampled(debug_status_o)));

  ////////////////////
  // Stimulus tasks
  ////////////////////
  task automatic next_cycle();
    @(posedge clk);
    chk_ctl    <= 1'b0;
    chk_cause  <= 1'b0;
    chk_irq    <= 1'b0;
    chk_mode   <= 1'b0;
    chk_status <= 1'b0;
  endtask

  // Let pending checks fire before the test name changes
  task automatic drain_checks();
    next_cycle();
    next_cycle();
  endtask

  task automatic expect_ctl(input ctrl_out_t c);
    exp_ctl <= c;
    chk_ctl <= 1'b1;
  endtask

  task automatic expect_mode(input logic m);
    exp_mode <= m;
    chk_mode <= 1'b1;
  endtask

  task automatic clear_stages();
    id_i      <= '0;
    ex_i      <= '0;
    wb_i      <= '0;
    irq_req_i <= 1'b0;
  endtask

  task automatic boot_core();
    test_name = "boot";
    repeat (3) next_cycle();
    fetch_enable_i <= 1'b1;
    booted         <= 1'b1;
    repeat (3) next_cycle();
    exp_status <= 3'b010;
    chk_status <= 1'b1;
    expect_ctl(idle_ctl());
    drain_checks();
  endtask

  task automatic exception_sweep();
    logic [31:0] rnd;
    wb_stage_t   w;
    ctrl_out_t   c;
    test_name = "wb_exception";
    for (int i = 0; i < 16; i++) begin
      rnd     = $urandom;
      w       = rnd[7:0];
      w.valid = 1'b1;
      if (!(w.bus_err || w.illegal || w.ecall || w.ebreak)) begin
        w.ecall = 1'b1;
      end
      c                = redirect_ctl('1, PC_EXCEPTION);
      c.csr_save_stage = MASK_WB;
      c.csr_save_cause = 1'b1;
      // Branches and jumps in flight lose to the exception
      wb_i      <= w;
      ex_i      <= rnd[11:8];
      id_i      <= rnd[14:12];
      exp_cause <= (IRQ_ID_W+1)'(expected_exc_code(w));
      chk_cause <= 1'b1;
      expect_ctl(c);
      next_cycle();
      clear_stages();
    end
    drain_checks();
  endtask

  task automatic interrupt_sweep();
    logic [31:0]         rnd;
    logic [IRQ_ID_W-1:0] irq_id;
    id_stage_t           id;
    ex_stage_t           ex;
    wb_stage_t           w;
    ctrl_out_t           c;
    test_name = "interrupt";
    for (int i = 0; i < 8; i++) begin
      rnd            = $urandom;
      id             = '0;
      ex             = '0;
      w              = '0;
      id.valid       = rnd[0];
      id.jump        = rnd[1];
      ex.valid       = rnd[2];
      ex.branch      = rnd[3];
      ex.branch_taken = rnd[4];
      w.valid        = rnd[5];
      w.wfi          = rnd[6];
      irq_id         = rnd[IRQ_ID_W+7:8];
      c                = redirect_ctl('1, PC_EXCEPTION);
      c.exc_pc_mux     = EXC_PC_IRQ;
      c.csr_save_stage = oldest_valid_stage(id.valid, ex.valid, w.valid);
      c.csr_save_cause = 1'b1;
      id_i      <= id;
      ex_i      <= ex;
      wb_i      <= w;
      irq_req_i <= 1'b1;
      irq_id_i  <= irq_id;
      exp_irq   <= {1'b1, irq_id};
      chk_irq   <= 1'b1;
      exp_cause <= {1'b1, irq_id};
      chk_cause <= 1'b1;
      expect_ctl(c);
      next_cycle();
      clear_stages();
    end
    drain_checks();
    // Load in WB holds the interrupt off
    test_name  = "interrupt_blocked";
    w          = '0;
    w.valid    = 1'b1;
    w.data_req = 1'b1;
    c          = idle_ctl();
    c.halt     = MASK_ID;
    wb_i      <= w;
    irq_req_i <= 1'b1;
    irq_id_i  <= IRQ_ID_W'($urandom);
    exp_irq   <= '0;
    chk_irq   <= 1'b1;
    expect_ctl(c);
    next_cycle();
    clear_stages();
    drain_checks();
  endtask

  task automatic transfer_case(input id_stage_t id, input ex_stage_t ex, input ctrl_out_t c);
    id_i <= id;
    ex_i <= ex;
    expect_ctl(c);
    next_cycle();
    clear_stages();
  endtask

  task automatic branch_and_jump();
    test_name = "control_transfer";
    // Stage fields are valid, jump, jr_stall and valid, branch, taken, misaligned
    transfer_case(3'b000, 4'b1110, redirect_ctl(MASK_IF | MASK_ID, PC_BRANCH));
    transfer_case(3'b000, 4'b1100, idle_ctl());
    transfer_case(3'b110, 4'b0000, redirect_ctl(MASK_IF, PC_JUMP));
    transfer_case(3'b111, 4'b0000, idle_ctl());
    transfer_case(3'b110, 4'b1110, redirect_ctl(MASK_IF | MASK_ID, PC_BRANCH));
    drain_checks();
  endtask

  task automatic sleep_and_wake();
    wb_stage_t w;
    ctrl_out_t c;
    test_name = "wfi_sleep";
    w         = '0;
    w.valid   = 1'b1;
    w.wfi     = 1'b1;
    c           = idle_ctl();
    c.instr_req = 1'b0;
    c.halt      = MASK_IF | MASK_ID;
    wb_i <= w;
    expect_ctl(c);
    next_cycle();
    clear_stages();
    c.busy = 1'b0;
    c.halt = '1;
    repeat (3) begin
      expect_ctl(c);
      next_cycle();
    end
    // Busy comes back in the wakeup cycle
    irq_wakeup_i <= 1'b1;
    c.busy = 1'b1;
    expect_ctl(c);
    next_cycle();
    irq_wakeup_i <= 1'b0;
    expect_ctl(idle_ctl());
    drain_checks();
  endtask

  task automatic debug_round_trip();
    wb_stage_t w;
    ctrl_out_t c;
    test_name = "debug_entry";
    data_req_i <= 1'b1;
    ex_valid_i <= 1'b0;
    next_cycle();
    data_req_i  <= 1'b0;
    debug_req_i <= 1'b1;
    c      = idle_ctl();
    c.halt = MASK_ID;
    expect_ctl(c);
    next_cycle();
    // Request pulse is over, only the sticky copy remains
    debug_req_i <= 1'b0;
    expect_ctl(c);
    next_cycle();
    ex_valid_i <= 1'b1;
    expect_ctl(c);
    next_cycle();
    ex_valid_i <= 1'b0;
    c.halt = '1;
    expect_ctl(c);
    expect_mode(1'b0);
    next_cycle();
    c                = redirect_ctl('1, PC_EXCEPTION);
    c.exc_pc_mux     = EXC_PC_DBD;
    c.csr_save_stage = MASK_IF;
    c.csr_save_cause = 1'b1;
    c.debug_csr_save = 1'b1;
    expect_ctl(c);
    expect_mode(1'b0);
    next_cycle();
    exp_status <= 3'b001;
    chk_status <= 1'b1;
    expect_ctl(idle_ctl());
    expect_mode(1'b1);
    drain_checks();

    test_name = "debug_exception";
    w         = '0;
    w.valid   = 1'b1;
    w.illegal = 1'b1;
    c                = redirect_ctl('1, PC_EXCEPTION);
    c.exc_pc_mux     = EXC_PC_DBE;
    c.csr_save_stage = MASK_WB;
    wb_i <= w;
    expect_ctl(c);
    expect_mode(1'b1);
    next_cycle();
    clear_stages();
    drain_checks();

    test_name = "dret";
    w         = '0;
    w.valid   = 1'b1;
    w.dret    = 1'b1;
    wb_i <= w;
    expect_ctl(redirect_ctl(MASK_IF | MASK_ID | MASK_EX, PC_DRET));
    expect_mode(1'b1);
    next_cycle();
    clear_stages();
    exp_status <= 3'b010;
    chk_status <= 1'b1;
    expect_ctl(idle_ctl());
    expect_mode(1'b0);
    drain_checks();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    void'($urandom(63124));
    errors         = 0;
    cycles         = 0;
    test_name      = "reset";
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    id_i           = '0;
    ex_i           = '0;
    wb_i           = '0;
    irq_req_i      = 1'b0;
    irq_id_i       = '0;
    irq_wakeup_i   = 1'b0;
    debug_req_i    = 1'b0;
    data_req_i     = 1'b0;
    ex_valid_i     = 1'b0;
    booted         = 1'b0;
    chk_ctl        = 1'b0;
    chk_cause      = 1'b0;
    chk_irq        = 1'b0;
    chk_mode       = 1'b0;
    chk_status     = 1'b0;
    exp_ctl        = '0;
    exp_cause      = '0;
    exp_irq        = '0;
    exp_mode       = 1'b0;
    exp_status     = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    boot_core();
    exception_sweep();
    interrupt_sweep();
    branch_and_jump();
    sleep_and_wake();
    debug_round_trip();
    $display("run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ctrl_top.f
common/ctrl_pkg.sv
common/dbg_pkg.sv
rtl/ctrl_event_decode.sv
rtl/ctrl_main_fsm.sv
rtl/ctrl_debug_status.sv
rtl/ctrl_top.sv
verification/ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module ctrl_tb -Mdir "$BUILD_DIR" -f ctrl_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vctrl_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
